/* source/dnaSearchPkg.sv */
`default_nettype none

package dnaSearchPkg;

    // One sequence letter
    typedef logic [1:0] baseT;  // A=0 C=1 T=2 G=3

    // One pattern code
    typedef logic [2:0] patternCodeT;  // 0 to 3 are bases, 6 is never valid

    localparam patternCodeT CodeAlt2 = 3'd4;  // Two distinct bases follow
    localparam patternCodeT CodeAlt3 = 3'd5;  // Three distinct bases follow
    localparam patternCodeT CodeEnd  = 3'd7;

    // Set of bases one element allows, bit n for base n
    typedef logic [3:0] baseMaskT;

    typedef enum logic [1:0] {
        elementMatch,
        elementEnd,
        elementMalformed
    } elementKindT;

    localparam int DefaultSequenceDepth = 32;
    localparam int DefaultPatternDepth  = 16;

    // Wide enough to hold the depth itself
    typedef logic [$clog2(DefaultSequenceDepth + 1) - 1:0] sequenceAddrT;
    typedef logic [$clog2(DefaultPatternDepth + 1) - 1:0] patternAddrT;

endpackage

`default_nettype wire

/* source/symbolMemory.sv */
`default_nettype none
`timescale 1ns/10ps

module symbolMemory #(
    parameter int Depth = 16,
    parameter type PayloadT = logic
) (
    input wire logic clock,
    input wire logic write,
    input wire logic [$clog2(Depth) - 1:0] writeAddress,
    input wire PayloadT writeData,
    input wire logic [$clog2(Depth) - 1:0] readAddress,
    output PayloadT readData
);

    PayloadT words [Depth];

    // Read returns the old word on a same-address write
    always_ff @(posedge clock) begin
        if (write) begin
            words[writeAddress] <= writeData;
        end
        readData <= words[readAddress];  // One cycle read latency
    end

endmodule

`default_nettype wire

/* source/patternDecoder.sv */
`default_nettype none
`timescale 1ns/10ps

module patternDecoder #(
    parameter int PatternDepth = dnaSearchPkg::DefaultPatternDepth
) (
    input wire logic clock,
    input wire logic reset_N,
    input wire logic fetch,
    input wire dnaSearchPkg::patternAddrT elementAddress,
    output dnaSearchPkg::patternAddrT patternReadAddress,
    input wire dnaSearchPkg::patternCodeT patternCode,
    output logic elementReady,
    output dnaSearchPkg::elementKindT elementKind,
    output dnaSearchPkg::baseMaskT allowedBases,
    output dnaSearchPkg::patternAddrT nextElementAddress
);

    typedef enum logic [1:0] {
        idle,
        opening,
        member
    } stateT;

    stateT state;
    stateT nextState;
    dnaSearchPkg::patternAddrT readPointer;  // Next code address to read
    dnaSearchPkg::baseMaskT collected;
    dnaSearchPkg::baseMaskT codeBit;
    logic [1:0] membersLeft;
    logic [1:0] memberCount;
    logic codeIsBase;
    logic overrun;

    assign codeIsBase = (patternCode[2] == 1'b0);
    assign codeBit = dnaSearchPkg::baseMaskT'(4'b0001 << patternCode[1:0]);
    assign memberCount = (patternCode == dnaSearchPkg::CodeAlt3) ? 2'd3 : 2'd2;
    // Alternative whose members would fall past the last code
    assign overrun = (int'(readPointer) + int'(memberCount) > PatternDepth);

    always_comb begin
        nextState = state;
        elementReady = 1'b0;
        elementKind = dnaSearchPkg::elementMatch;
        allowedBases = codeBit;
        patternReadAddress = (state == idle) ? elementAddress : readPointer;
        nextElementAddress = readPointer;
        unique case (state)
            idle: begin
                if (fetch) begin
                    nextState = opening;
                end
            end
            opening: begin
                if (codeIsBase) begin
                    elementReady = 1'b1;
                    nextState = idle;
                end else if (patternCode == dnaSearchPkg::CodeEnd) begin
                    elementReady = 1'b1;
                    elementKind = dnaSearchPkg::elementEnd;
                    allowedBases = '0;
                    nextState = idle;
                end else if ((patternCode == dnaSearchPkg::CodeAlt2 ||
                              patternCode == dnaSearchPkg::CodeAlt3) && !overrun) begin
                    nextState = member;  // Read first member
                end else begin
                    elementReady = 1'b1;
                    elementKind = dnaSearchPkg::elementMalformed;
                    allowedBases = '0;
                    nextState = idle;
                end
            end
            member: begin
                allowedBases = collected | codeBit;
                if (!codeIsBase || (collected & codeBit) != '0) begin
                    elementReady = 1'b1;  // Bad member ends the element early
                    elementKind = dnaSearchPkg::elementMalformed;
                    nextState = idle;
                end else if (membersLeft == 2'd1) begin
                    elementReady = 1'b1;
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle) begin
            readPointer <= elementAddress + dnaSearchPkg::patternAddrT'(1);
        end else if (nextState == member) begin
            readPointer <= readPointer + dnaSearchPkg::patternAddrT'(1);
        end
        if (state == opening) begin
            collected <= '0;
            membersLeft <= memberCount;
        end else if (state == member) begin
            collected <= collected | codeBit;
            membersLeft <= membersLeft - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* source/matchController.sv */
`default_nettype none
`timescale 1ns/10ps

module matchController #(
    parameter int SequenceDepth = dnaSearchPkg::DefaultSequenceDepth,
    parameter int PatternDepth = dnaSearchPkg::DefaultPatternDepth
) (
    input wire logic clock,
    input wire logic reset_N,
    input wire logic start,
    input wire dnaSearchPkg::sequenceAddrT sequenceLength,
    output logic fetch,
    output dnaSearchPkg::patternAddrT elementAddress,
    input wire logic elementReady,
    input wire dnaSearchPkg::elementKindT elementKind,
    input wire dnaSearchPkg::baseMaskT allowedBases,
    input wire dnaSearchPkg::patternAddrT nextElementAddress,
    output dnaSearchPkg::sequenceAddrT sequenceReadAddress,
    input wire dnaSearchPkg::baseT sequenceBase,
    output logic busy,
    output logic done,
    output logic found,
    output dnaSearchPkg::sequenceAddrT matchPosition,
    output logic error
);

    typedef enum logic [1:0] {
        idle,
        validating,
        searching
    } stateT;

    stateT state;
    dnaSearchPkg::patternAddrT patternLength;  // Elements before the end code
    dnaSearchPkg::sequenceAddrT startPosition;
    dnaSearchPkg::sequenceAddrT letterAddress;
    dnaSearchPkg::sequenceAddrT searchLimit;
    logic baseAllowed;
    logic nextStartFits;

    // Never search past the sequence store
    assign searchLimit = (int'(sequenceLength) > SequenceDepth) ?
        dnaSearchPkg::sequenceAddrT'(SequenceDepth) : sequenceLength;
    assign baseAllowed = allowedBases[sequenceBase];
    assign nextStartFits =
        (int'(startPosition) + 1 + int'(patternLength) <= int'(searchLimit));
    assign sequenceReadAddress = letterAddress;

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state <= idle;
            busy <= 1'b0;
            done <= 1'b0;
            found <= 1'b0;
            error <= 1'b0;
            matchPosition <= '0;
            fetch <= 1'b0;
            elementAddress <= '0;
            patternLength <= '0;
            startPosition <= '0;
            letterAddress <= '0;
        end else begin
            fetch <= 1'b0;
            done <= 1'b0;
            unique case (state)
                idle: begin
                    if (start) begin
                        state <= validating;
                        busy <= 1'b1;
                        found <= 1'b0;
                        error <= 1'b0;
                        matchPosition <= '0;
                        fetch <= 1'b1;
                        elementAddress <= '0;
                        patternLength <= '0;
                    end
                end
                validating: begin
                    if (elementReady) begin
                        unique case (elementKind)
                            dnaSearchPkg::elementEnd: begin
                                startPosition <= '0;
                                letterAddress <= '0;
                                elementAddress <= '0;
                                if (int'(patternLength) > int'(searchLimit)) begin
                                    state <= idle;  // Pattern longer than sequence
                                    busy <= 1'b0;
                                    done <= 1'b1;
                                end else begin
                                    state <= searching;
                                    fetch <= 1'b1;
                                end
                            end
                            dnaSearchPkg::elementMatch: begin
                                patternLength <= patternLength + dnaSearchPkg::patternAddrT'(1);
                                elementAddress <= nextElementAddress;
                                if (int'(nextElementAddress) >= PatternDepth) begin
                                    state <= idle;  // Codes ran out with no end
                                    busy <= 1'b0;
                                    done <= 1'b1;
                                    error <= 1'b1;
                                end else begin
                                    fetch <= 1'b1;
                                end
                            end
                            default: begin
                                state <= idle;
                                busy <= 1'b0;
                                done <= 1'b1;
                                error <= 1'b1;
                            end
                        endcase
                    end
                end
                searching: begin
                    if (elementReady) begin
                        if (elementKind == dnaSearchPkg::elementEnd) begin
                            state <= idle;
                            busy <= 1'b0;
                            done <= 1'b1;
                            found <= 1'b1;
                            matchPosition <= startPosition;
                        end else if (elementKind == dnaSearchPkg::elementMatch &&
                                     baseAllowed) begin
                            elementAddress <= nextElementAddress;
                            letterAddress <= letterAddress + dnaSearchPkg::sequenceAddrT'(1);
                            fetch <= 1'b1;
                        end else if (!nextStartFits) begin
                            state <= idle;  // No start position left
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else begin
                            startPosition <= startPosition + dnaSearchPkg::sequenceAddrT'(1);
                            letterAddress <= startPosition + dnaSearchPkg::sequenceAddrT'(1);
                            elementAddress <= '0;
                            fetch <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dnaSearchTop.sv */
`default_nettype none
`timescale 1ns/10ps

module dnaSearchTop #(
    parameter int SequenceDepth = dnaSearchPkg::DefaultSequenceDepth,
    parameter int PatternDepth = dnaSearchPkg::DefaultPatternDepth
) (
    input wire logic clock,
    input wire logic reset_N,
    input wire logic patternWrite,
    input wire logic [$clog2(PatternDepth) - 1:0] patternWriteAddress,
    input wire dnaSearchPkg::patternCodeT patternWriteCode,
    input wire logic sequenceWrite,
    input wire logic [$clog2(SequenceDepth) - 1:0] sequenceWriteAddress,
    input wire dnaSearchPkg::baseT sequenceWriteBase,
    input wire dnaSearchPkg::sequenceAddrT sequenceLength,
    input wire logic start,
    output wire logic busy,
    output wire logic done,
    output wire logic found,
    output wire logic error,
    output wire dnaSearchPkg::sequenceAddrT matchPosition
);

    wire logic fetch;
    wire logic elementReady;
    wire dnaSearchPkg::patternAddrT elementAddress;
    wire dnaSearchPkg::patternAddrT nextElementAddress;
    wire dnaSearchPkg::patternAddrT patternReadAddress;
    wire dnaSearchPkg::patternCodeT patternCode;
    wire dnaSearchPkg::elementKindT elementKind;
    wire dnaSearchPkg::baseMaskT allowedBases;
    wire dnaSearchPkg::sequenceAddrT sequenceReadAddress;
    wire dnaSearchPkg::baseT sequenceBase;

    symbolMemory #(
        .Depth(PatternDepth),
        .PayloadT(dnaSearchPkg::patternCodeT)
    ) i_patternMemory (
        .clock(clock),
        .write(patternWrite),
        .writeAddress(patternWriteAddress),
        .writeData(patternWriteCode),
        .readAddress(patternReadAddress[$clog2(PatternDepth) - 1:0]),
        .readData(patternCode)
    );

    symbolMemory #(
        .Depth(SequenceDepth),
        .PayloadT(dnaSearchPkg::baseT)
    ) i_sequenceMemory (
        .clock(clock),
        .write(sequenceWrite),
        .writeAddress(sequenceWriteAddress),
        .writeData(sequenceWriteBase),
        .readAddress(sequenceReadAddress[$clog2(SequenceDepth) - 1:0]),
        .readData(sequenceBase)
    );

    patternDecoder #(
        .PatternDepth(PatternDepth)
    ) i_patternDecoder (
        .clock(clock),
        .reset_N(reset_N),
        .fetch(fetch),
        .elementAddress(elementAddress),
        .patternReadAddress(patternReadAddress),
        .patternCode(patternCode),
        .elementReady(elementReady),
        .elementKind(elementKind),
        .allowedBases(allowedBases),
        .nextElementAddress(nextElementAddress)
    );

    matchController #(
        .SequenceDepth(SequenceDepth),
        .PatternDepth(PatternDepth)
    ) i_matchController (
        .clock(clock),
        .reset_N(reset_N),
        .start(start),
        .sequenceLength(sequenceLength),
        .fetch(fetch),
        .elementAddress(elementAddress),
        .elementReady(elementReady),
        .elementKind(elementKind),
        .allowedBases(allowedBases),
        .nextElementAddress(nextElementAddress),
        .sequenceReadAddress(sequenceReadAddress),
        .sequenceBase(sequenceBase),
        .busy(busy),
        .done(done),
        .found(found),
        .matchPosition(matchPosition),
        .error(error)
    );

endmodule

`default_nettype wire

/* testbench/clockGenerator.sv */
`default_nettype none
`timescale 1ns/10ps

module clockGenerator #(
    parameter int HalfPeriod = 50,
    parameter int ResetCycles = 2
) (
    output logic clock,
    output logic reset_N
);

    initial begin
        clock = 1'b0;
        forever begin
            #HalfPeriod clock = ~clock;  // 100 ns period
        end
    end

    initial begin
        reset_N = 1'b0;
        repeat (ResetCycles) @(posedge clock);
        #1 reset_N = 1'b1;  // Released just after the edge
    end

endmodule

`default_nettype wire

/* testbench/dnaSearchChecker.sv */
`default_nettype none
`timescale 1ns/10ps

module dnaSearchChecker (
    input wire logic clock,
    input wire logic reset_N,
    input wire logic busy,
    input wire logic done,
    input wire logic found,
    input wire logic error
);

    int failureCount = 0;  // Failed assertions so far

    doneSingleCycle: assert property (@(posedge clock) disable iff (!reset_N)
        done |=> !done)
    else begin
        $error("done stayed high for two cycles");
        failureCount++;
    end

    foundErrorExclusive: assert property (@(posedge clock) disable iff (!reset_N)
        !(found && error))
    else begin
        $error("found and error are high together");
        failureCount++;
    end

    // Run is over when done pulses
    doneNotBusy: assert property (@(posedge clock) disable iff (!reset_N)
        done |-> !busy)
    else begin
        $error("busy is high while done pulses");
        failureCount++;
    end

endmodule

bind dnaSearchTop dnaSearchChecker i_checker (
    .clock(clock),
    .reset_N(reset_N),
    .busy(busy),
    .done(done),
    .found(found),
    .error(error)
);

`default_nettype wire

/* testbench/dnaSearchTb.sv */
`default_nettype none
`timescale 1ns/10ps

module dnaSearchTb;

    localparam int SequenceDepth = dnaSearchPkg::DefaultSequenceDepth;
    localparam int PatternDepth = dnaSearchPkg::DefaultPatternDepth;

    logic clock;
    logic reset_N;
    logic patternWrite;
    logic [$clog2(PatternDepth) - 1:0] patternWriteAddress;
    dnaSearchPkg::patternCodeT patternWriteCode;
    logic sequenceWrite;
    logic [$clog2(SequenceDepth) - 1:0] sequenceWriteAddress;
    dnaSearchPkg::baseT sequenceWriteBase;
    dnaSearchPkg::sequenceAddrT sequenceLength;
    logic start;
    logic busy;
    logic done;
    logic found;
    logic error;
    dnaSearchPkg::sequenceAddrT matchPosition;

    // One entry per row of buildTable
    string patternRows [$];
    string letterRows [$];
    int lengthRows [$];
    logic errorRows [$];
    logic foundRows [$];
    int positionRows [$];
    int cycleCount = 0;
    int cycleLimit = 0;

    clockGenerator i_clockGenerator (
        .clock(clock),
        .reset_N(reset_N)
    );

    dnaSearchTop #(
        .SequenceDepth(SequenceDepth),
        .PatternDepth(PatternDepth)
    ) i_dut (.*);

    task automatic addCase(input string pattern, input string letters, input int length,
                           input logic expectError, input logic expectFound,
                           input int expectPosition);
        patternRows.push_back(pattern);
        letterRows.push_back(letters);
        lengthRows.push_back(length);
        errorRows.push_back(expectError);
        foundRows.push_back(expectFound);
        positionRows.push_back(expectPosition);
    endtask

    task automatic buildTable();
        //      pattern             sequence                        length error found pos
        addCase("ACG7",             "TTACTACGAT",                       10, 1'b0, 1'b1, 5);
        addCase("GAT7",             "CCTGAGAT",                          8, 1'b0, 1'b1, 5);
        addCase("A4CGT7",           "ATTAGTCA",                          8, 1'b0, 1'b1, 3);
        addCase("5ACT4GA7",         "GGCTGCA",                           7, 1'b0, 1'b1, 3);
        addCase("GG7",   "ACTACTACTACTACTACTACTACTACTACTGG",            32, 1'b0, 1'b1, 30);
        addCase("7",                "ACGT",                              4, 1'b0, 1'b1, 0);
        addCase("TTT7",             "ATTATTGTT",                         9, 1'b0, 1'b0, 0);
        addCase("ACGTA7",           "ACGTACGT",                          4, 1'b0, 1'b0, 0);
        addCase("AC67",             "ACGT",                              4, 1'b1, 1'b0, 0);
        addCase("A4CC7",            "ACCT",                              4, 1'b1, 1'b0, 0);
        addCase("5AC47",            "ACGT",                              4, 1'b1, 1'b0, 0);
        addCase("ACGTACGTACGTACGT", "ACGTACGTACGTACGTACGT",             20, 1'b1, 1'b0, 0);
    endtask

    // A C T G are bases 0 to 3, digits 4 to 7 the other codes
    function automatic dnaSearchPkg::patternCodeT codeFromChar(input byte symbol);
        case (symbol)
            "A": return 3'd0;
            "C": return 3'd1;
            "T": return 3'd2;
            "G": return 3'd3;
            default: return dnaSearchPkg::patternCodeT'(symbol - "0");
        endcase
    endfunction

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %b, expected %b",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic checkPosition(input dnaSearchPkg::sequenceAddrT actual,
                                 input dnaSearchPkg::sequenceAddrT expected,
                                 input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic loadCase(input int index);
        string pattern;
        string letters;
        int address;
        pattern = patternRows[index];
        letters = letterRows[index];
        for (address = 0; address < SequenceDepth; address++) begin
            @(posedge clock);
            #1;
            patternWrite = (address < PatternDepth);
            patternWriteAddress = address[$clog2(PatternDepth) - 1:0];
            if (address < pattern.len()) begin
                patternWriteCode = codeFromChar(pattern[address]);
            end else begin
                patternWriteCode = dnaSearchPkg::patternCodeT'(address ^ (address >> 3));
            end
            sequenceWrite = 1'b1;
            sequenceWriteAddress = address[$clog2(SequenceDepth) - 1:0];
            if (address < letters.len()) begin
                sequenceWriteBase = dnaSearchPkg::baseT'(codeFromChar(letters[address]));
            end else begin
                sequenceWriteBase =
                    dnaSearchPkg::baseT'(address ^ (address >> 2) ^ (address >> 4));
            end
        end
        @(posedge clock);
        #1;
        patternWrite = 1'b0;
        sequenceWrite = 1'b0;
        sequenceLength = dnaSearchPkg::sequenceAddrT'(lengthRows[index]);
    endtask

    task automatic runCase(input int index);
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        checkFlag(busy, 1'b1, $sformatf("case %0d busy after start", index));
        @(posedge clock);
        #1;
        start = 1'b1;  // Second start while busy
        @(posedge clock);
        #1;
        start = 1'b0;
        @(negedge clock);
        while (done !== 1'b1) begin
            @(negedge clock);
        end
        checkFlag(error, errorRows[index], $sformatf("case %0d error", index));
        checkFlag(found, foundRows[index], $sformatf("case %0d found", index));
        checkPosition(matchPosition, dnaSearchPkg::sequenceAddrT'(positionRows[index]),
                      $sformatf("case %0d match position", index));
        @(negedge clock);
        checkFlag(found, foundRows[index], $sformatf("case %0d found held", index));
    endtask

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run took more than %0d clock cycles", cycleLimit);
            $display("Verification failed");
            $fatal(1, "Stopped by the cycle limit");
        end
    end

    always @(posedge clock) begin
        if (i_dut.i_checker.failureCount != 0) begin
            $display("An assertion of the checker failed at time %0t", $time);
            $display("Verification failed");
            $fatal(1, "Stopped at the first error");
        end
    end

    initial begin
        int index;
        patternWrite = 1'b0;
        patternWriteAddress = '0;
        patternWriteCode = '0;
        sequenceWrite = 1'b0;
        sequenceWriteAddress = '0;
        sequenceWriteBase = '0;
        sequenceLength = '0;
        start = 1'b0;
        buildTable();
        cycleLimit = patternRows.size() *
            (SequenceDepth * PatternDepth * 6 + PatternDepth * 5 + 100);
        wait (reset_N === 1'b1);
        @(negedge clock);
        checkFlag(busy, 1'b0, "busy after reset");
        checkFlag(done, 1'b0, "done after reset");
        checkFlag(found, 1'b0, "found after reset");
        checkFlag(error, 1'b0, "error after reset");
        checkPosition(matchPosition, '0, "match position after reset");
        for (index = 0; index < patternRows.size(); index++) begin
            loadCase(index);
            runCase(index);
        end
        @(negedge clock);
        if (i_dut.i_checker.failureCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/dnaSearchPkg.sv
source/symbolMemory.sv
source/patternDecoder.sv
source/matchController.sv
source/dnaSearchTop.sv
testbench/clockGenerator.sv
testbench/dnaSearchChecker.sv
testbench/dnaSearchTb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dnaSearchTb \
    -f verilog.f \
    -o dnaSearchSim

# A failing run exits nonzero, the log decides the result
./obj_dir/dnaSearchSim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "FAIL: the log holds no result"
    exit 1
fi
echo "PASS"
